// File: sim.f
logic/capture_pkg.sv
logic/capture_ifs.sv
logic/ccir656_decoder.sv
logic/raster_tracker.sv
logic/color_classifier.sv
logic/pixel_packer.sv
logic/ntsc_capture.sv
tests/ntsc_capture_chk.sv
tests/tb_ntsc_capture.sv

// File: tests/tb_ntsc_capture.sv
`timescale 1ns/100ps

module tb_ntsc_capture
   import capture_pkg::*;
();

   // Expected detection and pair records, due on a cycle count
   typedef struct packed {
      int unsigned    due;
      color_t         color;
      logic [X_W-1:0] x;
      logic [Y_W-1:0] y;
   } det_rec_t;

   typedef struct packed {
      int unsigned         due;
      logic [2*DISP_W-1:0] pixels;
   } pair_rec_t;

   localparam int LINES_PER_FIELD = 30;
   localparam int NUM_TESTS = 2;

   logic                clk = 1'b0;
   logic                reset;
   logic [SAMPLE_W-1:0] i_sample;
   logic                o_frame_start;
   logic                o_det_valid;
   color_t              o_color;
   logic [X_W-1:0]      o_x;
   logic [Y_W-1:0]      o_y;
   logic                o_pair_valid;
   logic [2*DISP_W-1:0] o_pixels;

   // Stimulus stream, built up front so the timeout is known
   logic [SAMPLE_W-1:0] stim[$];
   int unsigned         test_last[NUM_TESTS];
   string               test_name[NUM_TESTS];
   logic [15:0]         lfsr = 16'd37;
   int unsigned         cyc = 0;
   int unsigned         limit = 0;

   // Expected strobes
   det_rec_t            det_q[$];
   pair_rec_t           pair_q[$];
   int unsigned         fs_q[$];

   // Model state for decoder, raster and packer
   int                  m_pre = 0;
   int                  m_slot = -1;
   logic [SAMPLE_W-1:0] m_y = '0;
   logic [SAMPLE_W-1:0] m_cr = '0;
   logic [SAMPLE_W-1:0] m_cb = '0;
   logic                m_field = 1'b0;
   logic                m_fs_done = 1'b0;
   int                  m_line = 0;
   int                  m_x = 0;
   logic                m_phase = 1'b0;
   logic [DISP_W-1:0]   m_held = '0;

   // Scoreboard counts
   int                  checks = 0;
   int                  errors = 0;
   int                  det_seen = 0;
   int                  pair_seen = 0;
   int                  fs_seen = 0;
   int                  color_seen[4] = '{0, 0, 0, 0};

   ntsc_capture DUT (
      .clk           (clk),
      .reset         (reset),
      .i_sample      (i_sample),
      .o_frame_start (o_frame_start),
      .o_det_valid   (o_det_valid),
      .o_color       (o_color),
      .o_x           (o_x),
      .o_y           (o_y),
      .o_pair_valid  (o_pair_valid),
      .o_pixels      (o_pixels)
   );

   always
   begin
      #50 clk = ~clk;
   end

   // Cycle count and run limit
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (limit != 0 && cyc > limit)
      begin
         $display("Timeout: run still going after %0d cycles", cyc);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Random source, 16-bit Galois LFSR
   ////////////////////////////////////////////////////////////

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic pick(input logic [SAMPLE_W-1:0] base, input int nbits,
                       output logic [SAMPLE_W-1:0] v);
      logic [31:0] r;
      rand_bits(nbits, r);
      v = base + r[SAMPLE_W-1:0];
      // 000 and 3FF are reserved for sync
      if (v == SYNC_LO || v == SYNC_HI)
      begin
         v = 10'h200;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stream builder
   ////////////////////////////////////////////////////////////

   function automatic logic [SAMPLE_W-1:0] status_word(input logic f, input logic v,
                                                       input logic h);
      ccir_word_u w;
      w.status.fixed_one = 1'b1;
      w.status.field = f;
      w.status.vblank = v;
      w.status.hblank = h;
      // Standard protection bits
      w.status.protect = {v ^ h, f ^ h, f ^ v, f ^ v ^ h};
      w.status.low_bits = 2'b00;
      return w.sample;
   endfunction

   task automatic push_sync(input logic [SAMPLE_W-1:0] word);
      stim.push_back(SYNC_HI);
      stim.push_back(SYNC_LO);
      stim.push_back(SYNC_LO);
      stim.push_back(word);
   endtask

   // One Cb Y Cr Y group, mostly aimed at a marker box
   task automatic draw_group(output logic [SAMPLE_W-1:0] cb, output logic [SAMPLE_W-1:0] y0,
                             output logic [SAMPLE_W-1:0] cr, output logic [SAMPLE_W-1:0] y1);
      logic [31:0] kind;
      rand_bits(3, kind);
      case (kind)
         0:
         begin
            // Orange
            pick(10'h100, 7, cb);
            pick(10'h1A0, 7, y0);
            pick(10'h280, 7, cr);
            pick(10'h1A0, 7, y1);
         end
         1:
         begin
            // Green
            pick(10'h150, 6, cb);
            pick(10'h140, 7, y0);
            pick(10'h150, 6, cr);
            pick(10'h140, 7, y1);
         end
         2:
         begin
            // Pink
            pick(10'h250, 7, cb);
            pick(10'h220, 7, y0);
            pick(10'h250, 7, cr);
            pick(10'h220, 7, y1);
         end
         3:
         begin
            // Blue
            pick(10'h280, 7, cb);
            pick(10'h0A0, 7, y0);
            pick(10'h100, 7, cr);
            pick(10'h0A0, 7, y1);
         end
         default:
         begin
            pick(10'h000, 10, cb);
            pick(10'h000, 10, y0);
            pick(10'h000, 10, cr);
            pick(10'h000, 10, y1);
         end
      endcase
   endtask

   // Blanking word, active start, then 1 to 40 groups
   task automatic build_line(input logic f, input logic cut);
      logic [31:0]         n;
      logic [31:0]         cut_at;
      logic [SAMPLE_W-1:0] g[4];
      int                  idx;
      push_sync(status_word(f, 1'b0, 1'b1));
      push_sync(status_word(f, 1'b0, 1'b0));
      rand_bits(6, n);
      n = n % 40 + 1;
      cut_at = 32'hFFFF_FFFF;
      if (cut)
      begin
         rand_bits(8, cut_at);
         cut_at = cut_at % (4 * n);
      end
      idx = 0;
      for (int k = 0; k < n; k++)
      begin
         draw_group(g[0], g[1], g[2], g[3]);
         for (int j = 0; j < 4; j++)
         begin
            // Stray 3FF in mid-line
            stim.push_back((idx == cut_at) ? SYNC_HI : g[j]);
            idx++;
         end
      end
   endtask

   task automatic build_field(input logic f, input logic cuts);
      push_sync(status_word(f, 1'b1, 1'b0));
      for (int l = 0; l < LINES_PER_FIELD; l++)
      begin
         build_line(f, cuts && l[0]);
      end
   endtask

   // Tail lets the pipeline drain, the zero status word is rejected
   task automatic build_tail();
      stim.push_back(SYNC_HI);
      repeat (12)
      begin
         stim.push_back(SYNC_LO);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   task automatic classify(input logic [SAMPLE_W-1:0] y, input logic [SAMPLE_W-1:0] cr,
                           input logic [SAMPLE_W-1:0] cb, output logic hit,
                           output color_t col, output logic [DISP_W-1:0] disp);
      hit = 1'b1;
      col = COLOR_ORANGE;
      if (cb < ORANGE_CB_MAX && cr > ORANGE_CR_MIN && y > ORANGE_LUM_MIN)
      begin
         disp = {8'hFF, 5'b11111, 5'b00000};
      end
      else if (y > GREEN_LUM_MIN && y < GREEN_LUM_MAX && cr > GREEN_CR_MIN
               && cr < GREEN_CR_MAX && cb > GREEN_CB_MIN && cb < GREEN_CB_MAX)
      begin
         col = COLOR_GREEN;
         disp = {8'hFF, 5'b10000, 5'b00000};
      end
      else if (cb > PINK_CB_MIN && cr > PINK_CR_MIN && y > PINK_LUM_MIN)
      begin
         col = COLOR_PINK;
         disp = {8'hFF, 5'b11111, 5'b11111};
      end
      else if (cb > BLUE_CB_MIN && cr < BLUE_CR_MAX && y > BLUE_LUM_MIN)
      begin
         col = COLOR_BLUE;
         disp = {8'hFF, 5'b00000, 5'b11111};
      end
      else
      begin
         hit = 1'b0;
         disp = {y[9:2], cr[9:5], cb[9:5]};
      end
   endtask

   // Pixel strobe from a Y sample, outputs due 3 cycles on
   task automatic model_pixel(input int unsigned now);
      logic              hit;
      color_t            col;
      logic [DISP_W-1:0] disp;
      det_rec_t          d;
      pair_rec_t         p;
      if (m_line >= FIRST_LINE && m_line < LAST_LINE && m_x < ACTIVE_X)
      begin
         classify(m_y, m_cr, m_cb, hit, col, disp);
         if (hit)
         begin
            d.due = now + 3;
            d.color = col;
            d.x = X_W'(m_x);
            d.y = Y_W'(m_line - FIRST_LINE);
            det_q.push_back(d);
         end
         if (m_phase)
         begin
            p.due = now + 3;
            p.pixels = {m_held, disp};
            pair_q.push_back(p);
         end
         else
         begin
            m_held = disp;
         end
         m_phase = ~m_phase;
      end
      m_x++;
   endtask

   task automatic model_status(input ccir_word_u w, input int unsigned now);
      m_field = w.status.field;
      if (!m_field)
      begin
         m_fs_done = 1'b0;
      end
      // Vertical sync restarts on the field bit, each line steps by 2
      if (w.status.vblank)
      begin
         m_line = m_field;
         m_x = 0;
      end
      else if (w.status.hblank)
      begin
         if (m_line < LAST_LINE)
         begin
            m_line += 2;
         end
         m_x = 0;
      end
      else
      begin
         m_slot = 0;
      end
      if (m_field && !m_fs_done && (w.status.vblank || m_line >= LAST_LINE))
      begin
         fs_q.push_back(now + 1);
         m_fs_done = 1'b1;
      end
   endtask

   task automatic model_step(input logic [SAMPLE_W-1:0] s, input int unsigned now);
      ccir_word_u w;
      w.sample = s;
      if (m_slot >= 0)
      begin
         if (s == SYNC_HI)
         begin
            // Line is abandoned, the 3FF may open a new preamble
            m_slot = -1;
            m_pre = 1;
         end
         else
         begin
            case (m_slot)
               0: m_cb = s;
               2: m_cr = s;
               default:
               begin
                  m_y = s;
                  model_pixel(now);
               end
            endcase
            m_slot = (m_slot + 1) % 4;
         end
      end
      else if (m_pre == 3)
      begin
         m_pre = 0;
         if (w.status.fixed_one)
         begin
            model_status(w, now);
         end
      end
      else if (s == SYNC_LO && m_pre > 0)
      begin
         m_pre++;
      end
      else if (s == SYNC_HI && m_pre < 2)
      begin
         m_pre = 1;
      end
      else
      begin
         m_pre = 0;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_pulse(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %b got %b", $time, what, exp, got);
      end
   endtask

   task automatic check_color(input string what, input color_t got, input color_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
      end
   endtask

   task automatic check_coord(input string what, input logic [X_W-1:0] gx,
                              input logic [Y_W-1:0] gy, input logic [X_W-1:0] ex,
                              input logic [Y_W-1:0] ey);
      checks++;
      if (gx !== ex || gy !== ey)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected (%0d,%0d) got (%0d,%0d)",
                  $time, what, ex, ey, gx, gy);
      end
   endtask

   task automatic check_pixels(input string what, input logic [2*DISP_W-1:0] got,
                               input logic [2*DISP_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
      end
   endtask

   // Outputs are stable at the falling edge
   task automatic check_cycle();
      det_rec_t    d;
      pair_rec_t   p;
      logic        exp_det;
      logic        exp_pair;
      logic        exp_fs;
      exp_det = (det_q.size() > 0) && (det_q[0].due == cyc);
      exp_pair = (pair_q.size() > 0) && (pair_q[0].due == cyc);
      exp_fs = (fs_q.size() > 0) && (fs_q[0] == cyc);
      check_pulse("detection strobe", o_det_valid, exp_det);
      check_pulse("pair strobe", o_pair_valid, exp_pair);
      check_pulse("frame start", o_frame_start, exp_fs);
      if (exp_det)
      begin
         d = det_q.pop_front();
         check_color("detection colour", o_color, d.color);
         check_coord("detection position", o_x, o_y, d.x, d.y);
         color_seen[d.color]++;
      end
      if (exp_pair)
      begin
         p = pair_q.pop_front();
         check_pixels("pixel pair", o_pixels, p.pixels);
      end
      if (exp_fs)
      begin
         fs_q.delete(0);
      end
      det_seen += (o_det_valid === 1'b1);
      pair_seen += (o_pair_valid === 1'b1);
      fs_seen += (o_frame_start === 1'b1);
   endtask

   always @(negedge clk)
   begin
      if (!reset)
      begin
         check_cycle();
      end
   end

   // Summary line of one test, then its counts start over
   task automatic end_test(input int t, input int err_before);
      if (det_q.size() > 0 || pair_q.size() > 0 || fs_q.size() > 0)
      begin
         errors++;
         $display("Test %s ended with expected strobes that never came", test_name[t]);
      end
      $display("Test %s: %0d detections, %0d pairs, %0d frame starts, %0d errors",
               test_name[t], det_seen, pair_seen, fs_seen, errors - err_before);
      det_seen = 0;
      pair_seen = 0;
      fs_seen = 0;
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      int t;
      int err_before;
      reset = 1'b1;
      i_sample = '0;

      // Markers, pairs, window and frame starts over two frames
      test_name[0] = "fields";
      build_field(1'b0, 1'b0);
      build_field(1'b1, 1'b0);
      build_field(1'b0, 1'b0);
      build_field(1'b1, 1'b0);
      build_tail();
      test_last[0] = stim.size() - 1;
      // Stray 3FF on every other line
      test_name[1] = "resync";
      build_field(1'b0, 1'b1);
      build_field(1'b1, 1'b1);
      build_tail();
      test_last[1] = stim.size() - 1;
      limit = stim.size() + 8 + 200;

      repeat (8)
      begin
         @(posedge clk);
      end
      #1;
      reset = 1'b0;

      t = 0;
      err_before = 0;
      for (int i = 0; i < stim.size(); i++)
      begin
         @(posedge clk);
         #1;
         i_sample = stim[i];
         model_step(stim[i], cyc);
         if (i == test_last[t])
         begin
            end_test(t, err_before);
            err_before = errors;
            t++;
         end
      end
      repeat (5)
      begin
         @(posedge clk);
      end

      // Biased stimulus must have reached every colour box
      for (int c = 0; c < 4; c++)
      begin
         if (color_seen[c] == 0)
         begin
            errors++;
            $display("No detection of colour code %0d was produced", c);
         end
      end

      $display("Totals: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: tests/ntsc_capture_chk.sv
`timescale 1ns/100ps

// Output rules of the capture core, bound onto the top level
module ntsc_capture_chk
   import capture_pkg::*;
(
   input logic           clk,
   input logic           reset,
   input logic           i_det_valid,
   input logic           i_pair_valid,
   input logic           i_frame_start,
   input logic [X_W-1:0] i_x
);

   // Strobes held low while reset is applied
   det_quiet_in_reset: assert property (@(posedge clk) reset |=> !i_det_valid)
      else $error("o_det_valid went high during reset");

   pair_quiet_in_reset: assert property (@(posedge clk) reset |=> !i_pair_valid)
      else $error("o_pair_valid went high during reset");

   // Frame start is a single-cycle pulse
   frame_start_single: assert property (@(posedge clk) disable iff (reset)
      i_frame_start |=> !i_frame_start)
      else $error("o_frame_start high on two consecutive cycles");

   // Detections only come from the active width
   det_x_in_range: assert property (@(posedge clk) disable iff (reset)
      i_det_valid |-> (i_x < X_W'(ACTIVE_X)))
      else $error("o_x outside the active width on a detection");

endmodule

bind ntsc_capture ntsc_capture_chk u_chk (
   .clk           (clk),
   .reset         (reset),
   .i_det_valid   (o_det_valid),
   .i_pair_valid  (o_pair_valid),
   .i_frame_start (o_frame_start),
   .i_x           (o_x)
);

// File: logic/ntsc_capture.sv
`timescale 1ns/100ps

module ntsc_capture
   import capture_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic [SAMPLE_W-1:0] i_sample,
   output logic                o_frame_start,
   output logic                o_det_valid,
   output color_t              o_color,
   output logic [X_W-1:0]      o_x,
   output logic [Y_W-1:0]      o_y,
   output logic                o_pair_valid,
   output logic [2*DISP_W-1:0] o_pixels
);

   // Raster position handed to the classifier
   logic           in_window;
   logic [X_W-1:0] cur_x;
   logic [Y_W-1:0] cur_y;

   video_if vid ();
   pixel_if pix ();

   // Sample stream into components and sync strobes
   ccir656_decoder u_decoder (
      .clk      (clk),
      .reset    (reset),
      .i_sample (i_sample),
      .vid      (vid.source)
   );

   raster_tracker u_raster (
      .clk           (clk),
      .reset         (reset),
      .vid           (vid.sink),
      .o_in_window   (in_window),
      .o_x           (cur_x),
      .o_line        (cur_y),
      .o_frame_start (o_frame_start)
   );

   color_classifier u_classifier (
      .clk         (clk),
      .reset       (reset),
      .vid         (vid.sink),
      .i_in_window (in_window),
      .i_x         (cur_x),
      .i_line      (cur_y),
      .pix         (pix.source)
   );

   // Detection and pair strobes to the outside
   pixel_packer u_packer (
      .clk          (clk),
      .reset        (reset),
      .pix          (pix.sink),
      .o_det_valid  (o_det_valid),
      .o_color      (o_color),
      .o_x          (o_x),
      .o_y          (o_y),
      .o_pair_valid (o_pair_valid),
      .o_pixels     (o_pixels)
   );

endmodule

// File: logic/pixel_packer.sv
`timescale 1ns/100ps

module pixel_packer
   import capture_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   pixel_if.sink               pix,
   output logic                o_det_valid,
   output color_t              o_color,
   output logic [X_W-1:0]      o_x,
   output logic [Y_W-1:0]      o_y,
   output logic                o_pair_valid,
   output logic [2*DISP_W-1:0] o_pixels
);

   // Low on the even pixel of a pair
   logic              phase;
   logic [DISP_W-1:0] held;

   ////////////////////////////////////////////////////////////
   // Strobes and pair phase
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase <= 1'b0;
         o_det_valid <= 1'b0;
         o_pair_valid <= 1'b0;
      end
      else
      begin
         o_det_valid <= pix.pvalid && pix.hit;
         o_pair_valid <= pix.pvalid && phase;
         if (pix.pvalid)
         begin
            phase <= ~phase;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      // Detection record for every marker pixel
      if (pix.pvalid && pix.hit)
      begin
         o_color <= pix.color;
         o_x <= pix.x;
         o_y <= pix.y;
      end
      // Even pixel waits for its partner
      if (pix.pvalid && !phase)
      begin
         held <= pix.disp;
      end
      // Older pixel goes in the upper half
      if (pix.pvalid && phase)
      begin
         o_pixels <= {held, pix.disp};
      end
   end

endmodule

// File: logic/color_classifier.sv
`timescale 1ns/100ps

module color_classifier
   import capture_pkg::*;
(
   input  logic           clk,
   input  logic           reset,
   video_if.sink          vid,
   input  logic           i_in_window,
   input  logic [X_W-1:0] i_x,
   input  logic [Y_W-1:0] i_line,
   pixel_if.source        pix
);

   logic              take;
   logic              is_orange;
   logic              is_green;
   logic              is_pink;
   logic              is_blue;
   logic              hit_c;
   color_t            color_c;
   logic [DISP_W-1:0] disp_c;

   assign take = vid.pix_valid && i_in_window;

   // Threshold boxes
   assign is_orange = (vid.cb < ORANGE_CB_MAX) && (vid.cr > ORANGE_CR_MIN)
                      && (vid.luma > ORANGE_LUM_MIN);
   assign is_green = (vid.luma > GREEN_LUM_MIN) && (vid.luma < GREEN_LUM_MAX)
                     && (vid.cr > GREEN_CR_MIN) && (vid.cr < GREEN_CR_MAX)
                     && (vid.cb > GREEN_CB_MIN) && (vid.cb < GREEN_CB_MAX);
   assign is_pink = (vid.cb > PINK_CB_MIN) && (vid.cr > PINK_CR_MIN)
                    && (vid.luma > PINK_LUM_MIN);
   assign is_blue = (vid.cb > BLUE_CB_MIN) && (vid.cr < BLUE_CR_MAX)
                    && (vid.luma > BLUE_LUM_MIN);

   ////////////////////////////////////////////////////////////
   // Priority pick and display fill
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      hit_c = 1'b1;
      color_c = COLOR_ORANGE;
      // Orange first, then green, pink, blue
      if (is_orange)
      begin
         disp_c = {{LUMA_W{1'b1}}, {CHROMA_W{1'b1}}, {CHROMA_W{1'b0}}};
      end
      else if (is_green)
      begin
         color_c = COLOR_GREEN;
         disp_c = {{LUMA_W{1'b1}}, 1'b1, {(CHROMA_W-1){1'b0}}, {CHROMA_W{1'b0}}};
      end
      else if (is_pink)
      begin
         color_c = COLOR_PINK;
         disp_c = {{LUMA_W{1'b1}}, {CHROMA_W{1'b1}}, {CHROMA_W{1'b1}}};
      end
      else if (is_blue)
      begin
         color_c = COLOR_BLUE;
         disp_c = {{LUMA_W{1'b1}}, {CHROMA_W{1'b0}}, {CHROMA_W{1'b1}}};
      end
      else
      begin
         // Plain pixel keeps the top bits of each component
         hit_c = 1'b0;
         disp_c = {vid.luma[SAMPLE_W-1 -: LUMA_W], vid.cr[SAMPLE_W-1 -: CHROMA_W],
                   vid.cb[SAMPLE_W-1 -: CHROMA_W]};
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pix.pvalid <= 1'b0;
      end
      else
      begin
         pix.pvalid <= take;
      end
   end

   // Result and coordinates only move for window pixels
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         pix.hit <= hit_c;
         pix.color <= color_c;
         pix.disp <= disp_c;
         pix.x <= i_x;
         pix.y <= i_line;
      end
   end

endmodule

// File: logic/raster_tracker.sv
`timescale 1ns/100ps

module raster_tracker
   import capture_pkg::*;
(
   input  logic           clk,
   input  logic           reset,
   video_if.sink          vid,
   output logic           o_in_window,
   output logic [X_W-1:0] o_x,
   output logic [Y_W-1:0] o_line,
   output logic           o_frame_start
);

   logic [X_W-1:0] x_cnt;
   logic [Y_W-1:0] line_cnt;
   // Delayed vsync, field already holds the new bit here
   logic           vsync_q;
   // Once-per-field frame start latch
   logic           fs_done;
   logic           past_end;

   assign past_end = (line_cnt >= Y_W'(LAST_LINE));

   ////////////////////////////////////////////////////////////
   // Line and pixel counters
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         x_cnt <= '0;
         line_cnt <= '0;
         vsync_q <= 1'b0;
         fs_done <= 1'b0;
      end
      else
      begin
         vsync_q <= vid.vsync;
         // Vertical sync restarts the count on the field bit
         if (vsync_q)
         begin
            line_cnt <= Y_W'(vid.field);
            x_cnt <= '0;
         end
         else if (vid.hsync)
         begin
            // Interlaced so one field steps by two, held past the window
            if (!past_end)
            begin
               line_cnt <= line_cnt + Y_W'(2);
            end
            x_cnt <= '0;
         end
         else if (vid.pix_valid)
         begin
            x_cnt <= x_cnt + 1'b1;
         end

         // Latch clears once field 0 comes round again
         if (!vid.field)
         begin
            fs_done <= 1'b0;
         end
         else if (o_frame_start)
         begin
            fs_done <= 1'b1;
         end
      end
   end

   // Field 1 start on its vsync or on running off the bottom
   assign o_frame_start = (vsync_q || past_end) && vid.field && !fs_done;

   assign o_in_window = (line_cnt >= Y_W'(FIRST_LINE)) && !past_end
                        && (x_cnt < X_W'(ACTIVE_X));

   assign o_x = x_cnt;
   // Line number relative to the first visible line
   assign o_line = line_cnt - Y_W'(FIRST_LINE);

endmodule

// File: logic/ccir656_decoder.sv
`timescale 1ns/100ps

module ccir656_decoder
   import capture_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  ccir_word_u i_sample,
   video_if.source    vid
);

   logic [STATE_W-1:0] state;
   logic               is_hi;
   logic               is_lo;
   logic               status_ok;
   logic               active_start;
   logic               y_en;
   logic               cr_en;
   logic               cb_en;

   assign is_hi = (i_sample.sample == SYNC_HI);
   assign is_lo = (i_sample.sample == SYNC_LO);

   // Status word must carry its fixed top bit
   assign status_ok = (state == ST_XY) && i_sample.status.fixed_one;
   // SAV of a visible line has both blanking bits low
   assign active_start = status_ok && !i_sample.status.vblank && !i_sample.status.hblank;

   // Component enables, a 3FF inside the line is never taken as data
   assign y_en = ((state == ST_Y0) || (state == ST_Y1)) && !is_hi;
   assign cr_en = (state == ST_CR) && !is_hi;
   assign cb_en = (state == ST_CB) && !is_hi;

   // Sync strobes are live while the status word is on the input
   assign vid.hsync = status_ok && i_sample.status.hblank;
   assign vid.vsync = status_ok && i_sample.status.vblank;

   ////////////////////////////////////////////////////////////
   // Preamble search and Cb Y Cr Y walk
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_HUNT;
      end
      else
      begin
         case (state)
            ST_HUNT: state <= is_hi ? ST_LO1 : ST_HUNT;
            // Repeated 3FF keeps us at the first zero
            ST_LO1: state <= is_lo ? ST_LO2 : (is_hi ? ST_LO1 : ST_HUNT);
            ST_LO2: state <= is_lo ? ST_XY : ST_HUNT;
            // EAV and blanking codes drop back to the search
            ST_XY: state <= active_start ? ST_CB : ST_HUNT;
            // Mid-line 3FF is treated as the start of a new preamble
            ST_CB: state <= is_hi ? ST_LO1 : ST_Y0;
            ST_Y0: state <= is_hi ? ST_LO1 : ST_CR;
            ST_CR: state <= is_hi ? ST_LO1 : ST_Y1;
            ST_Y1: state <= is_hi ? ST_LO1 : ST_CB;
            default: state <= ST_HUNT;
         endcase
      end
   end

   // Pixel strobe follows each Y capture, field tracks the status word
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vid.pix_valid <= 1'b0;
         vid.field <= 1'b0;
      end
      else
      begin
         vid.pix_valid <= y_en;
         if (status_ok)
         begin
            vid.field <= i_sample.status.field;
         end
      end
   end

   // Component holding registers
   always_ff @(posedge clk)
   begin
      if (y_en)
      begin
         vid.luma <= i_sample.sample;
      end
      if (cr_en)
      begin
         vid.cr <= i_sample.sample;
      end
      if (cb_en)
      begin
         vid.cb <= i_sample.sample;
      end
   end

endmodule

// File: logic/capture_ifs.sv
`timescale 1ns/100ps

// Decoded component stream with its sync strobes
interface video_if
   import capture_pkg::*;
();
   logic [SAMPLE_W-1:0] luma;
   logic [SAMPLE_W-1:0] cr;
   logic [SAMPLE_W-1:0] cb;
   // One-cycle strobes
   logic                pix_valid;
   logic                vsync;
   logic                hsync;
   // Field level from the last status word
   logic                field;

   modport source (output luma, cr, cb, pix_valid, field, vsync, hsync);
   modport sink (input luma, cr, cb, pix_valid, field, vsync, hsync);
endinterface

// Classified window pixel with its coordinates
interface pixel_if
   import capture_pkg::*;
();
   logic              pvalid;
   logic              hit;
   color_t            color;
   logic [DISP_W-1:0] disp;
   logic [X_W-1:0]    x;
   logic [Y_W-1:0]    y;

   modport source (output pvalid, hit, color, disp, x, y);
   modport sink (input pvalid, hit, color, disp, x, y);
endinterface

// File: logic/capture_pkg.sv
package capture_pkg;

   ////////////////////////////////////////////////////////////
   // Stream and raster sizes
   ////////////////////////////////////////////////////////////

   // One CCIR656 sample and one colour component
   localparam int SAMPLE_W = 10;
   // Pixel and line counter widths
   localparam int X_W = 10;
   localparam int Y_W = 9;

   // Active window of the interlaced raster
   localparam int ACTIVE_X = 640;
   localparam int FIRST_LINE = 25;
   localparam int LAST_LINE = 505;

   // Display pixel is luma then Cr then Cb
   localparam int LUMA_W = 8;
   localparam int CHROMA_W = 5;
   localparam int DISP_W = LUMA_W + 2 * CHROMA_W;

   // Preamble words ahead of every status word
   localparam logic [SAMPLE_W-1:0] SYNC_HI = 10'h3FF;
   localparam logic [SAMPLE_W-1:0] SYNC_LO = 10'h000;

   // Decoder FSM encoding
   localparam int STATE_W = 3;
   localparam logic [STATE_W-1:0] ST_HUNT = 3'd0;
   localparam logic [STATE_W-1:0] ST_LO1 = 3'd1;
   localparam logic [STATE_W-1:0] ST_LO2 = 3'd2;
   localparam logic [STATE_W-1:0] ST_XY = 3'd3;
   localparam logic [STATE_W-1:0] ST_CB = 3'd4;
   localparam logic [STATE_W-1:0] ST_Y0 = 3'd5;
   localparam logic [STATE_W-1:0] ST_CR = 3'd6;
   localparam logic [STATE_W-1:0] ST_Y1 = 3'd7;

   ////////////////////////////////////////////////////////////
   // Marker colour thresholds
   ////////////////////////////////////////////////////////////

   // All tests are strict, neutral chroma sits at 200h
   localparam logic [SAMPLE_W-1:0] ORANGE_CB_MAX = 10'h1A0;
   localparam logic [SAMPLE_W-1:0] ORANGE_CR_MIN = 10'h260;
   localparam logic [SAMPLE_W-1:0] ORANGE_LUM_MIN = 10'h180;

   localparam logic [SAMPLE_W-1:0] GREEN_LUM_MIN = 10'h100;
   localparam logic [SAMPLE_W-1:0] GREEN_LUM_MAX = 10'h280;
   localparam logic [SAMPLE_W-1:0] GREEN_CR_MIN = 10'h140;
   localparam logic [SAMPLE_W-1:0] GREEN_CR_MAX = 10'h1C0;
   localparam logic [SAMPLE_W-1:0] GREEN_CB_MIN = 10'h140;
   localparam logic [SAMPLE_W-1:0] GREEN_CB_MAX = 10'h1C0;

   localparam logic [SAMPLE_W-1:0] PINK_CB_MIN = 10'h240;
   localparam logic [SAMPLE_W-1:0] PINK_CR_MIN = 10'h240;
   localparam logic [SAMPLE_W-1:0] PINK_LUM_MIN = 10'h200;

   localparam logic [SAMPLE_W-1:0] BLUE_CB_MIN = 10'h260;
   localparam logic [SAMPLE_W-1:0] BLUE_CR_MAX = 10'h1C0;
   localparam logic [SAMPLE_W-1:0] BLUE_LUM_MIN = 10'h080;

   // Marker colour codes
   typedef logic [1:0] color_t;
   localparam color_t COLOR_ORANGE = 2'd0;
   localparam color_t COLOR_PINK = 2'd1;
   localparam color_t COLOR_BLUE = 2'd2;
   localparam color_t COLOR_GREEN = 2'd3;

   // Sample word, read either as data or as a status word
   typedef union packed {
      logic [SAMPLE_W-1:0] sample;
      struct packed {
         logic       fixed_one;
         logic       field;
         logic       vblank;
         logic       hblank;
         logic [3:0] protect;
         logic [1:0] low_bits;
      } status;
   } ccir_word_u;

endpackage
